// ==== ntt_macros.svh ====
// Build-wide constants for the NTT subsystem
// NTT_N must be a power of two no larger than 512; the root is derived from it
// Memory holds two banks of NTT_N words, so NTT_MEM_ADDR_W tracks NTT_LOGN
`ifndef NTT_MACROS_SVH
`define NTT_MACROS_SVH

// Modulus and coefficient width
`define NTT_Q 8380417
`define NTT_COEF_W 23

// Transform size and number of passes
`define NTT_N 16
`define NTT_LOGN 4

// Primitive 512th root of unity mod q
// The N-th root is NTT_ROOT raised to NTT_ROOT_EXP
`define NTT_ROOT 1753
`define NTT_ROOT_EXP (512 / `NTT_N)

// Host and memory address map
`define NTT_HOST_ADDR_W 6
`define NTT_MEM_ADDR_W 5
`define NTT_CTRL_ADDR 32

`endif

// ==== ntt_pkg.sv ====
// Shared types for the NTT subsystem
// Host words carry one coefficient; the status word uses bits 1 and 0 only
`include "ntt_macros.svh"

package ntt_pkg;

    typedef enum logic [1:0] {
        MODE_FWD = 2'd0,
        MODE_INV = 2'd1,
        MODE_PWM = 2'd2
    } ntt_mode_t;

    typedef enum logic {
        HOST_WR = 1'b0,
        HOST_RD = 1'b1
    } host_op_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_t;

    // ==========================================================
    // Host side
    // ==========================================================
    typedef struct packed {
        logic                         valid;
        host_op_t                     op;
        logic [`NTT_HOST_ADDR_W-1:0]  addr;
        logic [`NTT_COEF_W-1:0]       wdata;
    } host_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   err;
        logic [`NTT_COEF_W-1:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic busy;
        logic done;
    } ntt_status_t;

    // ==========================================================
    // Engine side
    // ==========================================================
    typedef struct packed {
        logic                        en;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_a;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_b;
    } mem_rd_req_t;

    typedef struct packed {
        logic                        en_a;
        logic                        en_b;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_a;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_b;
        logic [`NTT_COEF_W-1:0]      data_a;
        logic [`NTT_COEF_W-1:0]      data_b;
    } mem_wr_req_t;

    typedef struct packed {
        logic                        valid;
        ntt_mode_t                   mode;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_a;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_b;
        logic [`NTT_COEF_W-1:0]      twiddle;
        logic                        last;
    } bfly_op_t;

    typedef struct packed {
        logic                        valid;
        logic                        two_writes;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_a;
        logic [`NTT_MEM_ADDR_W-1:0]  addr_b;
        logic [`NTT_COEF_W-1:0]      res_a;
        logic [`NTT_COEF_W-1:0]      res_b;
        logic                        last;
    } bfly_res_t;

endpackage

// ==== ntt_cmd_decode.sv ====
// Host request decode with a one-cycle read response
// Memory accesses and starts are dropped while the engine is busy
// Reads of unmapped addresses or made while busy return err
`include "ntt_macros.svh"

module ntt_cmd_decode
    import ntt_pkg::*;
(
    input  logic                        hclk,
    input  logic                        reset_i,
    input  host_req_t                   host_req_i,
    input  ntt_status_t                 status_i,
    input  logic [`NTT_COEF_W-1:0]      mem_rdata_i,
    output host_rsp_t                   host_rsp_o,
    output logic                        mem_host_en_o,
    output logic                        mem_host_we_o,
    output logic [`NTT_MEM_ADDR_W-1:0]  mem_host_addr_o,
    output logic [`NTT_COEF_W-1:0]      mem_host_wdata_o,
    output logic                        start_o,
    output ntt_mode_t                   start_mode_o
);

    logic        is_mem;
    logic        is_ctrl;
    logic        is_rd;
    logic        rd_valid_q;
    logic        rd_err_q;
    logic        rd_status_q;
    ntt_status_t status_q;

    // Address split
    assign is_mem  = (host_req_i.addr < `NTT_HOST_ADDR_W'(`NTT_CTRL_ADDR));
    assign is_ctrl = (host_req_i.addr == `NTT_HOST_ADDR_W'(`NTT_CTRL_ADDR));
    assign is_rd   = host_req_i.valid && (host_req_i.op == HOST_RD);

    assign mem_host_en_o    = host_req_i.valid && is_mem && !status_i.busy;
    assign mem_host_we_o    = (host_req_i.op == HOST_WR);
    assign mem_host_addr_o  = host_req_i.addr[`NTT_MEM_ADDR_W-1:0];
    assign mem_host_wdata_o = host_req_i.wdata;

    // Control write: bit 0 start, bits 2:1 mode
    assign start_o = host_req_i.valid && is_ctrl && (host_req_i.op == HOST_WR)
                     && host_req_i.wdata[0] && !status_i.busy;
    assign start_mode_o = ntt_mode_t'(host_req_i.wdata[2:1]);

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
            rd_err_q   <= 1'b0;
        end else begin
            rd_valid_q <= is_rd;
            rd_err_q   <= is_rd && !is_ctrl && (!is_mem || status_i.busy);
        end
    end

    // Mux select and status snapshot travel with the read
    always_ff @(posedge hclk) begin
        rd_status_q <= is_ctrl;
        status_q    <= status_i;
    end

    always_comb begin
        host_rsp_o.valid = rd_valid_q;
        host_rsp_o.err   = rd_err_q;
        if (rd_status_q) begin
            host_rsp_o.rdata = `NTT_COEF_W'({status_q.done, status_q.busy});
        end else begin
            host_rsp_o.rdata = mem_rdata_i;
        end
    end

    // Engine reports busy from the cycle after an accepted start
    a_start_busy: assert property (@(posedge hclk) disable iff (reset_i)
        start_o |=> status_i.busy);

endmodule

// ==== ntt_coef_mem.sv ====
// Two-bank coefficient store: bank A at 0..N-1, bank B at N..2N-1
// All read ports are registered; host and engine never write together
// because decode blocks host access while the engine runs
`include "ntt_macros.svh"

module ntt_coef_mem
    import ntt_pkg::*;
(
    input  logic                        hclk,
    input  logic                        host_en_i,
    input  logic                        host_we_i,
    input  logic [`NTT_MEM_ADDR_W-1:0]  host_addr_i,
    input  logic [`NTT_COEF_W-1:0]      host_wdata_i,
    input  mem_rd_req_t                 eng_rd_i,
    input  mem_wr_req_t                 eng_wr_i,
    output logic [`NTT_COEF_W-1:0]      host_rdata_o,
    output logic [`NTT_COEF_W-1:0]      eng_rdata_a_o,
    output logic [`NTT_COEF_W-1:0]      eng_rdata_b_o
);

    localparam int DEPTH = 2 * `NTT_N;

    logic [`NTT_COEF_W-1:0] mem [DEPTH];

    // Write ports
    always_ff @(posedge hclk) begin
        if (host_en_i && host_we_i) begin
            mem[host_addr_i] <= host_wdata_i;
        end
        if (eng_wr_i.en_a) begin
            mem[eng_wr_i.addr_a] <= eng_wr_i.data_a;
        end
        if (eng_wr_i.en_b) begin
            mem[eng_wr_i.addr_b] <= eng_wr_i.data_b;
        end
    end

    // Registered reads
    always_ff @(posedge hclk) begin
        if (host_en_i && !host_we_i) begin
            host_rdata_o <= mem[host_addr_i];
        end
        if (eng_rd_i.en) begin
            eng_rdata_a_o <= mem[eng_rd_i.addr_a];
            eng_rdata_b_o <= mem[eng_rd_i.addr_b];
        end
    end

    a_lane_conflict: assert property (@(posedge hclk)
        (eng_wr_i.en_a && eng_wr_i.en_b) |-> (eng_wr_i.addr_a != eng_wr_i.addr_b));

endmodule

// ==== ntt_sequencer.sv ====
// Pass sequencer for forward CT, inverse GS and pointwise multiply
// One operation per cycle; each pass drains before the next begins
// Twiddle tables are built at elaboration from NTT_ROOT
`include "ntt_macros.svh"

module ntt_sequencer
    import ntt_pkg::*;
(
    input  logic        hclk,
    input  logic        reset_i,
    input  logic        start_i,
    input  ntt_mode_t   start_mode_i,
    input  logic        pass_done_i,
    output logic        busy_o,
    output logic        last_pass_o,
    output mem_rd_req_t mem_rd_o,
    output bfly_op_t    op_o
);

    localparam int N    = `NTT_N;
    localparam int LOGN = `NTT_LOGN;
    localparam int CW   = `NTT_COEF_W;
    localparam int AW   = `NTT_MEM_ADDR_W;

    typedef logic [N/2-1:0][CW-1:0] tw_table_t;

    function automatic longint mod_pow(longint base, int exp);
        longint r;
        r = 1;
        for (int i = 0; i < exp; i++) begin
            r = (r * base) % `NTT_Q;
        end
        return r;
    endfunction

    // Powers 0..N/2-1 of the given root
    function automatic tw_table_t build_table(longint root);
        tw_table_t t;
        longint    w;
        w = 1;
        for (int i = 0; i < N/2; i++) begin
            t[i] = CW'(w);
            w    = (w * root) % `NTT_Q;
        end
        return t;
    endfunction

    localparam longint ROOT_N   = mod_pow(`NTT_ROOT, `NTT_ROOT_EXP);
    localparam longint ROOT_INV = mod_pow(ROOT_N, N - 1);
    localparam tw_table_t TW_FWD = build_table(ROOT_N);
    localparam tw_table_t TW_INV = build_table(ROOT_INV);

    seq_state_t        state_q;
    ntt_mode_t         mode_q;
    logic [LOGN-1:0]   pass_q;
    logic [LOGN-1:0]   idx_q;
    logic [LOGN-1:0]   last_idx;
    logic              issue;
    logic [LOGN-2:0]   bf_j;
    logic [LOGN-2:0]   grp;
    logic [LOGN-2:0]   grp_rev;
    logic [LOGN-1:0]   span_log;
    logic [LOGN-1:0]   bf_a;
    logic [LOGN-1:0]   span;

    assign issue       = (state_q == SEQ_ISSUE);
    assign busy_o      = (state_q != SEQ_IDLE);
    assign last_pass_o = (mode_q == MODE_PWM) || (pass_q == LOGN[LOGN-1:0] - 1'b1);
    assign last_idx    = (mode_q == MODE_PWM) ? LOGN'(N - 1) : LOGN'(N/2 - 1);

    // ==========================================================
    // Address and twiddle generation
    // ==========================================================
    // Forward span is N/2 >> pass, inverse span is 1 << pass
    always_comb begin
        bf_j     = idx_q[LOGN-2:0];
        span_log = (mode_q == MODE_INV) ? pass_q : LOGN'(LOGN - 1) - pass_q;
        span     = LOGN'(1) << span_log;
        grp      = bf_j >> span_log;
        bf_a     = (LOGN'(grp) << (span_log + 1'b1)) | (LOGN'(bf_j) & (span - 1'b1));
        for (int i = 0; i < LOGN - 1; i++) begin
            grp_rev[i] = grp[LOGN-2-i];
        end
    end

    always_comb begin
        op_o.valid = issue;
        op_o.mode  = mode_q;
        op_o.last  = (idx_q == last_idx);
        if (mode_q == MODE_PWM) begin
            op_o.addr_a  = AW'(idx_q);
            op_o.addr_b  = AW'(N) + AW'(idx_q);
            op_o.twiddle = '0;
        end else begin
            op_o.addr_a  = AW'(bf_a);
            op_o.addr_b  = AW'(bf_a | span);
            op_o.twiddle = (mode_q == MODE_INV) ? TW_INV[grp_rev] : TW_FWD[grp_rev];
        end
        mem_rd_o.en     = issue;
        mem_rd_o.addr_a = op_o.addr_a;
        mem_rd_o.addr_b = op_o.addr_b;
    end

    // ==========================================================
    // Pass FSM
    // ==========================================================
    always_ff @(posedge hclk) begin
        if (reset_i) begin
            state_q <= SEQ_IDLE;
            mode_q  <= MODE_FWD;
            pass_q  <= '0;
            idx_q   <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i) begin
                        mode_q  <= start_mode_i;
                        pass_q  <= '0;
                        idx_q   <= '0;
                        state_q <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    if (idx_q == last_idx) begin
                        idx_q   <= '0;
                        state_q <= SEQ_DRAIN;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                SEQ_DRAIN: begin
                    // Wait for the pass's last write before touching the data again
                    if (pass_done_i) begin
                        if (last_pass_o) begin
                            state_q <= SEQ_IDLE;
                        end else begin
                            pass_q  <= pass_q + 1'b1;
                            state_q <= SEQ_ISSUE;
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // Last write of a pass lands only after all its issues
    a_drain_quiet: assert property (@(posedge hclk) disable iff (reset_i)
        pass_done_i |-> (state_q == SEQ_DRAIN));

endmodule

// ==== ntt_butterfly.sv ====
// Two-stage modular pipeline; operands arrive one cycle after the issue
// Inputs are assumed already reduced below q
`include "ntt_macros.svh"

module ntt_butterfly
    import ntt_pkg::*;
(
    input  logic                    hclk,
    input  logic                    reset_i,
    input  bfly_op_t                op_i,
    input  logic [`NTT_COEF_W-1:0]  rdata_a_i,
    input  logic [`NTT_COEF_W-1:0]  rdata_b_i,
    output bfly_res_t               res_o
);

    localparam int CW = `NTT_COEF_W;
    localparam logic [CW:0] Q = (CW+1)'(`NTT_Q);

    bfly_op_t           op_q;
    bfly_op_t           s1_op;
    logic [CW-1:0]      s1_a;
    logic [CW-1:0]      s1_sum;
    logic [2*CW-1:0]    s1_prod;
    logic [CW:0]        add_w;
    logic [CW:0]        sub_w;
    logic [CW-1:0]      red_prod;
    logic [2*CW-1:0]    inv_prod;

    // Align the op with the memory read data
    always_ff @(posedge hclk) begin
        if (reset_i) begin
            op_q.valid  <= 1'b0;
            s1_op.valid <= 1'b0;
        end else begin
            op_q.valid  <= op_i.valid;
            s1_op.valid <= op_q.valid;
        end
    end

    // ==========================================================
    // Stage 1: multiply, or sum and difference for GS
    // ==========================================================
    always_comb begin
        add_w = {1'b0, rdata_a_i} + {1'b0, rdata_b_i};
        sub_w = {1'b0, rdata_a_i} + Q - {1'b0, rdata_b_i};
    end

    always_ff @(posedge hclk) begin
        op_q[$bits(bfly_op_t)-2:0]  <= op_i[$bits(bfly_op_t)-2:0];
        s1_op[$bits(bfly_op_t)-2:0] <= op_q[$bits(bfly_op_t)-2:0];
        s1_a   <= rdata_a_i;
        s1_sum <= CW'((add_w >= Q) ? add_w - Q : add_w);
        case (op_q.mode)
            MODE_FWD: s1_prod <= rdata_b_i * op_q.twiddle;
            MODE_INV: s1_prod <= (2*CW)'((sub_w >= Q) ? sub_w - Q : sub_w);
            default:  s1_prod <= rdata_a_i * rdata_b_i;
        endcase
    end

    // ==========================================================
    // Stage 2: reduce and combine
    // ==========================================================
    always_comb begin
        red_prod = CW'(s1_prod % `NTT_Q);
        inv_prod = s1_prod[CW-1:0] * s1_op.twiddle;
    end

    always_ff @(posedge hclk) begin
        if (reset_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= s1_op.valid;
        end
        res_o.two_writes <= (s1_op.mode != MODE_PWM);
        res_o.addr_a     <= s1_op.addr_a;
        res_o.addr_b     <= s1_op.addr_b;
        res_o.last       <= s1_op.last;
        case (s1_op.mode)
            MODE_FWD: begin
                res_o.res_a <= CW'(({1'b0, s1_a} + red_prod) % Q);
                res_o.res_b <= CW'(({1'b0, s1_a} + Q - red_prod) % Q);
            end
            MODE_INV: begin
                res_o.res_a <= s1_sum;
                res_o.res_b <= CW'(inv_prod % `NTT_Q);
            end
            default: begin
                res_o.res_a <= red_prod;
                res_o.res_b <= '0;
            end
        endcase
    end

    a_res_reduced: assert property (@(posedge hclk) disable iff (reset_i)
        res_o.valid |-> (res_o.res_a < Q[CW-1:0]) && (res_o.res_b < Q[CW-1:0]));

endmodule

// ==== ntt_writeback.sv ====
// Result commit and completion tracking
// Writes land at the clock edge that ends the result's valid cycle
`include "ntt_macros.svh"

module ntt_writeback
    import ntt_pkg::*;
(
    input  logic        hclk,
    input  logic        reset_i,
    input  bfly_res_t   res_i,
    input  logic        start_i,
    input  logic        last_pass_i,
    output mem_wr_req_t mem_wr_o,
    output logic        pass_done_o,
    output logic        done_o
);

    logic commit_last;

    // Lane B only for butterflies
    always_comb begin
        mem_wr_o.en_a   = res_i.valid;
        mem_wr_o.en_b   = res_i.valid && res_i.two_writes;
        mem_wr_o.addr_a = res_i.addr_a;
        mem_wr_o.addr_b = res_i.addr_b;
        mem_wr_o.data_a = res_i.res_a;
        mem_wr_o.data_b = res_i.res_b;
    end

    assign commit_last = res_i.valid && res_i.last;

    // Sequencer leaves drain on this, including after the final pass
    assign pass_done_o = commit_last;

    // Sticky done, cleared by the next start
    always_ff @(posedge hclk) begin
        if (reset_i) begin
            done_o <= 1'b0;
        end else if (start_i) begin
            done_o <= 1'b0;
        end else if (commit_last && last_pass_i) begin
            done_o <= 1'b1;
        end
    end

endmodule

// ==== ntt_subsys_top.sv ====
// NTT subsystem top: decode, memory, sequencer, butterfly, writeback
// Host port is a single-cycle request strobe without back-pressure
`include "ntt_macros.svh"

module ntt_subsys_top
    import ntt_pkg::*;
(
    input  logic      hclk,
    input  logic      reset_i,
    input  host_req_t host_req_i,
    output host_rsp_t host_rsp_o
);

    ntt_status_t                 status;
    logic                        mem_host_en;
    logic                        mem_host_we;
    logic [`NTT_MEM_ADDR_W-1:0]  mem_host_addr;
    logic [`NTT_COEF_W-1:0]      mem_host_wdata;
    logic [`NTT_COEF_W-1:0]      mem_host_rdata;
    logic                        start;
    ntt_mode_t                   start_mode;
    logic                        pass_done;
    logic                        last_pass;
    mem_rd_req_t                 eng_rd;
    mem_wr_req_t                 eng_wr;
    logic [`NTT_COEF_W-1:0]      eng_rdata_a;
    logic [`NTT_COEF_W-1:0]      eng_rdata_b;
    bfly_op_t                    bfly_op;
    bfly_res_t                   bfly_res;

    ntt_cmd_decode u_decode (
        .hclk(hclk), .reset_i(reset_i), .host_req_i(host_req_i), .status_i(status),
        .mem_rdata_i(mem_host_rdata), .host_rsp_o(host_rsp_o),
        .mem_host_en_o(mem_host_en), .mem_host_we_o(mem_host_we),
        .mem_host_addr_o(mem_host_addr), .mem_host_wdata_o(mem_host_wdata),
        .start_o(start), .start_mode_o(start_mode)
    );

    ntt_coef_mem u_mem (
        .hclk(hclk), .host_en_i(mem_host_en), .host_we_i(mem_host_we),
        .host_addr_i(mem_host_addr), .host_wdata_i(mem_host_wdata),
        .eng_rd_i(eng_rd), .eng_wr_i(eng_wr), .host_rdata_o(mem_host_rdata),
        .eng_rdata_a_o(eng_rdata_a), .eng_rdata_b_o(eng_rdata_b)
    );

    ntt_sequencer u_seq (
        .hclk(hclk), .reset_i(reset_i), .start_i(start), .start_mode_i(start_mode),
        .pass_done_i(pass_done), .busy_o(status.busy), .last_pass_o(last_pass),
        .mem_rd_o(eng_rd), .op_o(bfly_op)
    );

    ntt_butterfly u_bfly (
        .hclk(hclk), .reset_i(reset_i), .op_i(bfly_op), .rdata_a_i(eng_rdata_a),
        .rdata_b_i(eng_rdata_b), .res_o(bfly_res)
    );

    ntt_writeback u_wb (
        .hclk(hclk), .reset_i(reset_i), .res_i(bfly_res), .start_i(start),
        .last_pass_i(last_pass), .mem_wr_o(eng_wr), .pass_done_o(pass_done),
        .done_o(status.done)
    );

endmodule

// ==== tb_ntt_subsys.sv ====
// Testbench for the NTT subsystem through its host port
// Expected words come from a naive cyclic DFT model mod q
// Read responses are checked by concurrent assertions one cycle after each request
`include "ntt_macros.svh"

module tb_ntt_subsys
    import ntt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     N    = `NTT_N;
    localparam int     CW   = `NTT_COEF_W;
    localparam int     CTRL = `NTT_CTRL_ADDR;
    localparam longint Q    = `NTT_Q;

    logic          hclk;
    logic          reset_i;
    host_req_t     host_req;
    host_rsp_t     host_rsp;
    logic [31:0]   rng_state;
    longint        mem_img [2*N];
    longint        root_n;
    int            mismatch_count;
    int            fail_count;

    // Expected response of the read in flight
    logic          exp_check;
    logic          exp_err;
    logic [CW-1:0] exp_word;
    logic          rd_q;
    logic          chk_q;
    logic          err_q;
    logic          stat_q;
    logic [CW-1:0] word_q;

    ntt_subsys_top UUT (
        .hclk(hclk), .reset_i(reset_i), .host_req_i(host_req), .host_rsp_o(host_rsp)
    );

    always #50 hclk = ~hclk;

    always @(posedge hclk) begin
        rd_q   <= host_req.valid && (host_req.op == HOST_RD);
        chk_q  <= exp_check;
        err_q  <= exp_err;
        word_q <= exp_word;
        stat_q <= (host_req.addr == `NTT_HOST_ADDR_W'(CTRL));
    end

    // ============================================================
    // Response checks
    // ============================================================
    a_rsp_valid: assert property (@(posedge hclk) disable iff (reset_i)
        host_rsp.valid == rd_q)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: host_rsp.valid got %b expected %b",
                     $time, $sampled(host_rsp.valid), $sampled(rd_q));
        end

    a_rsp_err: assert property (@(posedge hclk) disable iff (reset_i)
        (rd_q && chk_q) |-> (host_rsp.err == err_q))
        else begin
            mismatch_count++;
            $display("mismatch at %0t: host_rsp.err got %b expected %b",
                     $time, $sampled(host_rsp.err), $sampled(err_q));
        end

    a_rsp_data: assert property (@(posedge hclk) disable iff (reset_i)
        (rd_q && chk_q && !err_q) |-> (host_rsp.rdata == word_q))
        else begin
            mismatch_count++;
            $display("mismatch at %0t: host_rsp.rdata got %0d expected %0d",
                     $time, $sampled(host_rsp.rdata), $sampled(word_q));
        end

    // Done and busy never show together
    a_status_end: assert property (@(posedge hclk) disable iff (reset_i)
        (rd_q && stat_q && !host_rsp.err) |-> !(host_rsp.rdata[1] && host_rsp.rdata[0]))
        else begin
            fail_count++;
            $display("at %0t the status shows done while the engine is still busy", $time);
        end

    // ============================================================
    // Software model
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic longint pow_mod(input longint base, input int e);
        longint r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = (r * base) % Q;
        end
        return r;
    endfunction

    function automatic int bitrev(input int v);
        int r;
        r = 0;
        for (int i = 0; i < `NTT_LOGN; i++) begin
            r = r | (((v >> i) & 1) << (`NTT_LOGN - 1 - i));
        end
        return r;
    endfunction

    // Natural-order bank A in, transform out at bit-reversed addresses
    task automatic model_forward();
        longint x [N];
        longint acc;
        for (int j = 0; j < N; j++) begin
            x[j] = mem_img[j];
        end
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int j = 0; j < N; j++) begin
                acc = (acc + x[j] * pow_mod(root_n, (j * k) % N)) % Q;
            end
            mem_img[bitrev(k)] = acc;
        end
    endtask

    // Bit-reversed input, natural output, no scaling by N inverse
    task automatic model_inverse();
        longint y [N];
        longint root_inv;
        longint acc;
        root_inv = pow_mod(root_n, N - 1);
        for (int k = 0; k < N; k++) begin
            y[k] = mem_img[bitrev(k)];
        end
        for (int n = 0; n < N; n++) begin
            acc = 0;
            for (int k = 0; k < N; k++) begin
                acc = (acc + y[k] * pow_mod(root_inv, (n * k) % N)) % Q;
            end
            mem_img[n] = acc;
        end
    endtask

    task automatic model_pointwise();
        for (int i = 0; i < N; i++) begin
            mem_img[i] = (mem_img[i] * mem_img[N + i]) % Q;
        end
    endtask

    // ============================================================
    // Host tasks
    // ============================================================
    task automatic host_write(input int addr, input logic [CW-1:0] data);
        host_req.valid = 1'b1;
        host_req.op    = HOST_WR;
        host_req.addr  = `NTT_HOST_ADDR_W'(addr);
        host_req.wdata = data;
        @(posedge hclk);
        #5;
        host_req.valid = 1'b0;
    endtask

    task automatic host_read(input int addr, output logic [CW-1:0] data);
        host_req.valid = 1'b1;
        host_req.op    = HOST_RD;
        host_req.addr  = `NTT_HOST_ADDR_W'(addr);
        host_req.wdata = '0;
        @(posedge hclk);
        #5;
        host_req.valid = 1'b0;
        data = host_rsp.rdata;
    endtask

    task automatic read_expect(input int addr, input longint word, input logic err);
        logic [CW-1:0] data;
        exp_check = 1'b1;
        exp_err   = err;
        exp_word  = CW'(word);
        host_read(addr, data);
    endtask

    task automatic start_engine(input ntt_mode_t mode);
        host_write(CTRL, CW'({mode, 1'b1}));
    endtask

    task automatic load_bank(input int base);
        for (int i = 0; i < N; i++) begin
            rng_state = xorshift32(rng_state);
            mem_img[base + i] = longint'(rng_state) % Q;
            host_write(base + i, CW'(mem_img[base + i]));
        end
    endtask

    task automatic check_memory();
        for (int a = 0; a < 2 * N; a++) begin
            read_expect(a, mem_img[a], 1'b0);
        end
    endtask

    // Poll status until done, one read per cycle
    task automatic wait_done(output logic ok);
        logic [CW-1:0] status;
        int            polls;
        polls     = 0;
        exp_check = 1'b0;
        host_read(CTRL, status);
        while (!status[1] && polls < 2000) begin
            polls++;
            host_read(CTRL, status);
        end
        ok = status[1];
        if (!ok) begin
            fail_count++;
            $display("timeout at %0t: done did not rise within 2000 cycles", $time);
        end
    endtask

    task automatic run_tests();
        logic ok;
        read_expect(CTRL, 0, 1'b0);
        load_bank(0);
        load_bank(N);
        check_memory();

        // Pointwise multiply, bank B must stay as loaded
        start_engine(MODE_PWM);
        wait_done(ok);
        if (!ok) begin
            return;
        end
        model_pointwise();
        check_memory();

        // Forward, then inverse back to N times the input
        load_bank(0);
        start_engine(MODE_FWD);
        wait_done(ok);
        if (!ok) begin
            return;
        end
        model_forward();
        check_memory();
        start_engine(MODE_INV);
        wait_done(ok);
        if (!ok) begin
            return;
        end
        model_inverse();
        check_memory();

        // Host traffic while busy is dropped
        // Bank B is outside the forward transform, so a stray write would stay visible
        load_bank(0);
        start_engine(MODE_FWD);
        read_expect(0, 0, 1'b1);
        host_write(N + 1, CW'(12345));
        read_expect(CTRL, 1, 1'b0);
        start_engine(MODE_PWM);
        wait_done(ok);
        if (!ok) begin
            return;
        end
        model_forward();
        check_memory();
        read_expect(CTRL, 2, 1'b0);
        read_expect(CTRL, 2, 1'b0);
        start_engine(MODE_INV);
        read_expect(CTRL, 1, 1'b0);
        wait_done(ok);
        if (!ok) begin
            return;
        end
        model_inverse();
        check_memory();
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        hclk           = 1'b0;
        reset_i        = 1'b1;
        host_req       = '0;
        rng_state      = 32'd98577;
        mismatch_count = 0;
        fail_count     = 0;
        exp_check      = 1'b0;
        exp_err        = 1'b0;
        exp_word       = '0;
        root_n         = pow_mod(`NTT_ROOT, `NTT_ROOT_EXP);
        repeat (8) @(posedge hclk);
        #5;
        reset_i = 1'b0;
        run_tests();
        // Let the last response reach its check
        repeat (2) @(posedge hclk);
        #5;
        finish_run();
    end

endmodule

// ==== files.f ====
+incdir+.
ntt_pkg.sv
ntt_cmd_decode.sv
ntt_coef_mem.sv
ntt_sequencer.sv
ntt_butterfly.sv
ntt_writeback.sv
ntt_subsys_top.sv
tb_ntt_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the NTT subsystem testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_ntt_subsys -o tb_ntt_subsys > build.log 2>&1 \
    && ./obj_dir/tb_ntt_subsys > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
